// File: hdl/nird_pkg.sv
package nird_pkg;

    // frame geometry.
    localparam int IMG_COLS = 16;
    localparam int IMG_ROWS = 16;

    // window and sampling geometry.
    localparam int WIN      = 5;
    localparam int WIN_AREA = WIN * WIN;
    localparam int WIN_CTR  = WIN / 2;
    localparam int R_IN     = 1;
    localparam int R_OUT    = 2;

    localparam int NUM_NEIGH = 8;

    // unit steps per direction, k * 45 degrees, row grows downwards.
    localparam int DIR_DR [NUM_NEIGH] = '{0, -1, -1, -1, 0, 1, 1, 1};
    localparam int DIR_DC [NUM_NEIGH] = '{1, 1, 0, -1, -1, -1, 0, 1};

    // riu2 code constants.
    localparam int MAX_TRANS       = 2;
    localparam int NONUNIFORM_CODE = 9;

    typedef logic [7:0] pixel_t;
    typedef logic [$clog2(IMG_COLS)-1:0] col_t;
    typedef logic [$clog2(IMG_ROWS)-1:0] row_t;

    // wide enough for 25 * 255.
    typedef logic [12:0] sum_t;

    // bit k is direction k * 45 degrees.
    typedef logic [NUM_NEIGH-1:0] pattern_t;

    typedef logic [3:0] code_t;

    // row 0 oldest, column WIN-1 newest.
    typedef pixel_t [WIN-1:0][WIN-1:0] window_t;

endpackage

// File: hdl/pixel_if.sv
`timescale 1ns/1ns

interface pixel_if;

    logic                valid;
    nird_pkg::pixel_t    pixel;
    nird_pkg::col_t      col;
    // window above and left of this pixel is complete.
    logic                full;
    logic                last;

    modport scan (
        output valid,
        output pixel,
        output col,
        output full,
        output last
    );

    modport store (
        input valid,
        input pixel,
        input col,
        input full,
        input last
    );

endinterface

// File: hdl/pattern_if.sv
`timescale 1ns/1ns

interface pattern_if;

    logic                 valid;
    nird_pkg::pattern_t   rd_pat;
    nird_pkg::pattern_t   ni_pat;
    // pattern of the frame's final window.
    logic                 last;

    modport enc (
        output valid,
        output rd_pat,
        output ni_pat,
        output last
    );

    modport map (
        input valid,
        input rd_pat,
        input ni_pat,
        input last
    );

endinterface

// File: hdl/pixel_scan.sv
`timescale 1ns/1ns

module pixel_scan (
    input  logic              clk,
    input  logic              arst_n_i,
    input  nird_pkg::pixel_t  pixel_i,
    input  logic              pixel_valid_i,
    pixel_if.scan             px
);

    nird_pkg::col_t col_q;
    nird_pkg::row_t row_q;
    logic           col_end;
    logic           row_end;

    assign col_end = (col_q == nird_pkg::col_t'(nird_pkg::IMG_COLS - 1));
    assign row_end = (row_q == nird_pkg::row_t'(nird_pkg::IMG_ROWS - 1));

    // raster position of the next pixel.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            col_q <= '0;
            row_q <= '0;
        end else if (pixel_valid_i) begin
            if (col_end) begin
                col_q <= '0;
                row_q <= row_end ? '0 : row_q + 1'b1;
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            px.valid <= 1'b0;
            px.col   <= '0;
            px.full  <= 1'b0;
            px.last  <= 1'b0;
        end else begin
            px.valid <= pixel_valid_i;
            if (pixel_valid_i) begin
                px.col  <= col_q;
                px.full <= (row_q >= nird_pkg::row_t'(nird_pkg::WIN - 1)) &&
                           (col_q >= nird_pkg::col_t'(nird_pkg::WIN - 1));
                px.last <= row_end && col_end;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pixel_valid_i) begin
            px.pixel <= pixel_i;
        end
    end

    // strobe must be known once out of reset.
    a_valid_known: assert property (
        @(posedge clk) disable iff (!arst_n_i) !$isunknown(pixel_valid_i)
    );

endmodule

// File: hdl/line_window.sv
`timescale 1ns/1ns

module line_window (
    input  logic               clk,
    input  logic               arst_n_i,
    pixel_if.store             px,
    output logic               win_valid_o,
    output nird_pkg::window_t  win_o,
    output logic               win_last_o
);

    // line_mem[0] is four rows back, line_mem[WIN-2] the row just above.
    nird_pkg::pixel_t line_mem [nird_pkg::WIN-1][nird_pkg::IMG_COLS];

    // column entering the window, oldest row first.
    nird_pkg::pixel_t new_col [nird_pkg::WIN];

    always_comb begin
        for (int r = 0; r < nird_pkg::WIN - 1; r++) begin
            new_col[r] = line_mem[r][px.col];
        end
        new_col[nird_pkg::WIN-1] = px.pixel;
    end

    // each row moves up one line at this column.
    always_ff @(posedge clk) begin
        if (px.valid) begin
            for (int r = 0; r < nird_pkg::WIN - 1; r++) begin
                line_mem[r][px.col] <= new_col[r+1];
            end
        end
    end

    // shift left and append the new column.
    always_ff @(posedge clk) begin
        if (px.valid) begin
            for (int r = 0; r < nird_pkg::WIN; r++) begin
                for (int c = 0; c < nird_pkg::WIN - 1; c++) begin
                    win_o[r][c] <= win_o[r][c+1];
                end
                win_o[r][nird_pkg::WIN-1] <= new_col[r];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            win_valid_o <= 1'b0;
            win_last_o  <= 1'b0;
        end else begin
            win_valid_o <= px.valid && px.full;
            win_last_o  <= px.valid && px.last;
        end
    end

    // the frame's last pixel always closes a window.
    a_last_is_full: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        px.valid && px.last |-> px.full
    );

endmodule

// File: hdl/nird_encode.sv
`timescale 1ns/1ns

module nird_encode (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               win_valid_i,
    input  nird_pkg::window_t  win_i,
    input  logic               win_last_i,
    pattern_if.enc             pat
);

    nird_pkg::sum_t   patch_sum;
    nird_pkg::sum_t   sum_q;
    nird_pkg::pixel_t outer_q [nird_pkg::NUM_NEIGH];
    nird_pkg::pixel_t inner_q [nird_pkg::NUM_NEIGH];
    logic             valid_q;
    logic             last_q;

    // full 5x5 patch sum.
    always_comb begin
        patch_sum = '0;
        for (int r = 0; r < nird_pkg::WIN; r++) begin
            for (int c = 0; c < nird_pkg::WIN; c++) begin
                patch_sum += nird_pkg::sum_t'(win_i[r][c]);
            end
        end
    end

    // stage one, samples at whole pixel positions.
    always_ff @(posedge clk) begin
        if (win_valid_i) begin
            sum_q <= patch_sum;
            for (int k = 0; k < nird_pkg::NUM_NEIGH; k++) begin
                outer_q[k] <= win_i[nird_pkg::WIN_CTR + nird_pkg::R_OUT * nird_pkg::DIR_DR[k]]
                                   [nird_pkg::WIN_CTR + nird_pkg::R_OUT * nird_pkg::DIR_DC[k]];
                inner_q[k] <= win_i[nird_pkg::WIN_CTR + nird_pkg::R_IN * nird_pkg::DIR_DR[k]]
                                   [nird_pkg::WIN_CTR + nird_pkg::R_IN * nird_pkg::DIR_DC[k]];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= win_valid_i;
            last_q  <= win_valid_i && win_last_i;
        end
    end

    // stage two. mean test as sample * 25 >= sum.
    always_ff @(posedge clk) begin
        if (valid_q) begin
            for (int k = 0; k < nird_pkg::NUM_NEIGH; k++) begin
                pat.rd_pat[k] <= (outer_q[k] >= inner_q[k]);
                pat.ni_pat[k] <= (nird_pkg::sum_t'(outer_q[k]) *
                                  nird_pkg::sum_t'(nird_pkg::WIN_AREA)) >= sum_q;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pat.valid <= 1'b0;
            pat.last  <= 1'b0;
        end else begin
            pat.valid <= valid_q;
            pat.last  <= valid_q && last_q;
        end
    end

endmodule

// File: hdl/riu2_map.sv
`timescale 1ns/1ns

module riu2_map (
    input  logic             clk,
    input  logic             arst_n_i,
    pattern_if.map           pat,
    output nird_pkg::code_t  rd_o,
    output nird_pkg::code_t  ni_o,
    output logic             code_valid_o,
    output logic             frame_done_o
);

    // ones count if uniform, else the non-uniform code.
    function automatic nird_pkg::code_t riu2(input nird_pkg::pattern_t p);
        int trans;
        int ones;
        trans = 0;
        ones  = 0;
        for (int k = 0; k < nird_pkg::NUM_NEIGH; k++) begin
            // circular neighbour, bit 7 wraps to bit 0.
            trans += int'(p[k] != p[(k + 1) % nird_pkg::NUM_NEIGH]);
            ones  += int'(p[k]);
        end
        if (trans <= nird_pkg::MAX_TRANS) begin
            return nird_pkg::code_t'(ones);
        end
        return nird_pkg::code_t'(nird_pkg::NONUNIFORM_CODE);
    endfunction

    always_ff @(posedge clk) begin
        if (pat.valid) begin
            rd_o <= riu2(pat.rd_pat);
            ni_o <= riu2(pat.ni_pat);
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            code_valid_o <= 1'b0;
            frame_done_o <= 1'b0;
        end else begin
            code_valid_o <= pat.valid;
            frame_done_o <= pat.valid && pat.last;
        end
    end

    // patterns must be known when strobed.
    a_pattern_known: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        pat.valid |-> !$isunknown({pat.rd_pat, pat.ni_pat, pat.last})
    );

endmodule

// File: hdl/nird_top.sv
`timescale 1ns/1ns

module nird_top (
    input  logic              clk,
    input  logic              arst_n_i,
    input  nird_pkg::pixel_t  pixel_i,
    input  logic              pixel_valid_i,
    output nird_pkg::code_t   rd_o,
    output nird_pkg::code_t   ni_o,
    output logic              code_valid_o,
    output logic              frame_done_o
);

    pixel_if   px_if ();
    pattern_if pat_if ();

    logic               win_valid;
    nird_pkg::window_t  win;
    logic               win_last;

    // raster scan.
    pixel_scan i_pixel_scan (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .pixel_i       (pixel_i),
        .pixel_valid_i (pixel_valid_i),
        .px            (px_if.scan)
    );

    // line store and 5x5 window.
    line_window i_line_window (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .px          (px_if.store),
        .win_valid_o (win_valid),
        .win_o       (win),
        .win_last_o  (win_last)
    );

    // RD and NI patterns.
    nird_encode i_nird_encode (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .win_valid_i (win_valid),
        .win_i       (win),
        .win_last_i  (win_last),
        .pat         (pat_if.enc)
    );

    riu2_map i_riu2_map (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .pat          (pat_if.map),
        .rd_o         (rd_o),
        .ni_o         (ni_o),
        .code_valid_o (code_valid_o),
        .frame_done_o (frame_done_o)
    );

endmodule

// File: sim/tb_nird.sv
`timescale 1ns/1ns

module tb_nird;

    localparam int CLK_HALF    = 20;
    localparam int DRIVE_SKEW  = 2;
    localparam int CODE_DELAY  = 5;
    localparam int DRAIN_LIMIT = 20;
    localparam int FRAME_PIX   = nird_pkg::IMG_COLS * nird_pkg::IMG_ROWS;
    localparam int WATCHDOG_NS = 2 * (4 * FRAME_PIX * 4 + 100) * 2 * CLK_HALF;

    // window positions, 3 bits per direction, direction 0 lowest.
    localparam logic [23:0] OUT_ROWS = {3'd4, 3'd4, 3'd4, 3'd2, 3'd0, 3'd0, 3'd0, 3'd2};
    localparam logic [23:0] OUT_COLS = {3'd4, 3'd2, 3'd0, 3'd0, 3'd0, 3'd2, 3'd4, 3'd4};
    localparam logic [23:0] IN_ROWS  = {3'd3, 3'd3, 3'd3, 3'd2, 3'd1, 3'd1, 3'd1, 3'd2};
    localparam logic [23:0] IN_COLS  = {3'd3, 3'd2, 3'd1, 3'd1, 3'd1, 3'd2, 3'd3, 3'd3};

    logic              clk;
    logic              arst_n_i;
    nird_pkg::pixel_t  pixel_i;
    logic              pixel_valid_i;
    nird_pkg::code_t   rd_o;
    nird_pkg::code_t   ni_o;
    logic              code_valid_o;
    logic              frame_done_o;

    nird_pkg::pixel_t  frame [nird_pkg::IMG_ROWS][nird_pkg::IMG_COLS];
    nird_pkg::code_t   exp_rd_q [$];
    nird_pkg::code_t   exp_ni_q [$];
    bit                exp_last_q [$];
    int                exp_cycle_q [$];
    int                cycle_cnt = 0;
    int                done_cnt = 0;
    int                errors = 0;
    string             cur_test = "none";

    nird_top i_dut (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .pixel_i       (pixel_i),
        .pixel_valid_i (pixel_valid_i),
        .rd_o          (rd_o),
        .ni_o          (ni_o),
        .code_valid_o  (code_valid_o),
        .frame_done_o  (frame_done_o)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic check_code(input string what, input nird_pkg::code_t exp,
                              input nird_pkg::code_t act);
        if (exp !== act) begin
            errors++;
            $display("Fail %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input bit exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Fail %s %s: expected %0b, actual %0b", cur_test, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (exp != act) begin
            errors++;
            $display("Fail %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
        end
    endtask

    // ones count when the circular pattern has at most two edges.
    function automatic nird_pkg::code_t riu2_code(input nird_pkg::pattern_t p);
        nird_pkg::pattern_t rot;
        int edges;
        int ones;
        rot   = {p[0], p[nird_pkg::NUM_NEIGH-1:1]};
        edges = 0;
        ones  = 0;
        for (int k = 0; k < nird_pkg::NUM_NEIGH; k++) begin
            edges += (p[k] ^ rot[k]) ? 1 : 0;
            ones  += p[k] ? 1 : 0;
        end
        if (edges > 2) begin
            return nird_pkg::code_t'(nird_pkg::NONUNIFORM_CODE);
        end
        return nird_pkg::code_t'(ones);
    endfunction

    // model of the window whose newest pixel is (r, c).
    task automatic push_expected(input int r, input int c, input int fixed_code);
        nird_pkg::pattern_t rd_pat;
        nird_pkg::pattern_t ni_pat;
        int top;
        int left;
        int sum;
        int outer;
        int inner;
        top  = r - (nird_pkg::WIN - 1);
        left = c - (nird_pkg::WIN - 1);
        sum  = 0;
        for (int wr = 0; wr < nird_pkg::WIN; wr++) begin
            for (int wc = 0; wc < nird_pkg::WIN; wc++) begin
                sum += frame[top+wr][left+wc];
            end
        end
        for (int k = 0; k < nird_pkg::NUM_NEIGH; k++) begin
            outer = frame[top+OUT_ROWS[3*k +: 3]][left+OUT_COLS[3*k +: 3]];
            inner = frame[top+IN_ROWS[3*k +: 3]][left+IN_COLS[3*k +: 3]];
            rd_pat[k] = (outer >= inner);
            ni_pat[k] = (outer * nird_pkg::WIN_AREA >= sum);
        end
        if (fixed_code >= 0) begin
            exp_rd_q.push_back(nird_pkg::code_t'(fixed_code));
            exp_ni_q.push_back(nird_pkg::code_t'(fixed_code));
        end else begin
            exp_rd_q.push_back(riu2_code(rd_pat));
            exp_ni_q.push_back(riu2_code(ni_pat));
        end
        exp_last_q.push_back((r == nird_pkg::IMG_ROWS - 1) && (c == nird_pkg::IMG_COLS - 1));
        exp_cycle_q.push_back(cycle_cnt);
    endtask

    task automatic fill_flat(input nird_pkg::pixel_t value);
        for (int r = 0; r < nird_pkg::IMG_ROWS; r++) begin
            for (int c = 0; c < nird_pkg::IMG_COLS; c++) begin
                frame[r][c] = value;
            end
        end
    endtask

    task automatic fill_random();
        for (int r = 0; r < nird_pkg::IMG_ROWS; r++) begin
            for (int c = 0; c < nird_pkg::IMG_COLS; c++) begin
                frame[r][c] = nird_pkg::pixel_t'($urandom);
            end
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_SKEW;
            pixel_valid_i = 1'b0;
        end
    endtask

    // raster strobes; the last strobe is left high for the caller.
    task automatic send_frame(input int max_gap, input int fixed_code);
        int gap;
        for (int r = 0; r < nird_pkg::IMG_ROWS; r++) begin
            for (int c = 0; c < nird_pkg::IMG_COLS; c++) begin
                @(posedge clk);
                #DRIVE_SKEW;
                pixel_valid_i = 1'b1;
                pixel_i       = frame[r][c];
                if (r >= nird_pkg::WIN - 1 && c >= nird_pkg::WIN - 1) begin
                    push_expected(r, c, fixed_code);
                end
                if (max_gap > 0) begin
                    gap = $urandom_range(max_gap, 0);
                    idle(gap);
                end
            end
        end
    endtask

    task automatic wait_codes();
        int guard;
        guard = 0;
        while (exp_rd_q.size() > 0 && guard < DRAIN_LIMIT) begin
            @(posedge clk);
            guard++;
        end
        if (exp_rd_q.size() > 0) begin
            errors++;
            $display("%s: %0d expected codes never appeared", cur_test, exp_rd_q.size());
            exp_rd_q.delete();
            exp_ni_q.delete();
            exp_last_q.delete();
            exp_cycle_q.delete();
        end
        idle(3);
    endtask

    // pops one expected code per output strobe.
    always @(negedge clk) begin
        if (arst_n_i) begin
            if (frame_done_o && !code_valid_o) begin
                errors++;
                $display("%s: frame_done_o high without a code", cur_test);
            end
            if (code_valid_o) begin
                if (exp_rd_q.size() == 0) begin
                    errors++;
                    $display("%s: code_valid_o pulsed with no code expected", cur_test);
                end else begin
                    check_code("rd_o", exp_rd_q.pop_front(), rd_o);
                    check_code("ni_o", exp_ni_q.pop_front(), ni_o);
                    check_flag("frame_done_o", exp_last_q.pop_front(), frame_done_o);
                    check_count("latency", CODE_DELAY, cycle_cnt - exp_cycle_q.pop_front());
                end
            end
            if (frame_done_o) begin
                done_cnt++;
            end
        end
    end

    task automatic test_reset();
        cur_test = "test_reset";
        arst_n_i = 1'b0;
        repeat (5) begin
            @(posedge clk);
            #DRIVE_SKEW;
            check_flag("code_valid_o", 1'b0, code_valid_o);
            check_flag("frame_done_o", 1'b0, frame_done_o);
        end
        arst_n_i = 1'b1;
        repeat (6) begin
            idle(1);
            check_flag("code_valid_o", 1'b0, code_valid_o);
            check_flag("frame_done_o", 1'b0, frame_done_o);
        end
    endtask

    // constant frame gives all-ones patterns.
    task automatic test_flat();
        cur_test = "test_flat";
        fill_flat(8'h5a);
        send_frame(0, 8);
        idle(1);
        wait_codes();
    endtask

    task automatic test_random_burst();
        cur_test = "test_random_burst";
        fill_random();
        send_frame(0, -1);
        idle(1);
        wait_codes();
    endtask

    task automatic test_random_gaps();
        cur_test = "test_random_gaps";
        fill_random();
        send_frame(3, -1);
        idle(1);
        wait_codes();
    endtask

    // two frames back to back, counters must wrap.
    task automatic test_frame_end();
        int done_before;
        cur_test    = "test_frame_end";
        done_before = done_cnt;
        fill_random();
        send_frame(0, -1);
        fill_random();
        send_frame(1, -1);
        idle(1);
        wait_codes();
        check_count("frame_done_o pulses", 2, done_cnt - done_before);
    endtask

    initial begin
        arst_n_i      = 1'b0;
        pixel_i       = '0;
        pixel_valid_i = 1'b0;
        void'($urandom(35847));
        test_reset();
        test_flat();
        test_random_burst();
        test_random_gaps();
        test_frame_end();
        $display("run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #WATCHDOG_NS;
        $display("watchdog expired in %s, the run did not finish in time", cur_test);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: build.f
hdl/nird_pkg.sv
hdl/pixel_if.sv
hdl/pattern_if.sv
hdl/pixel_scan.sv
hdl/line_window.sv
hdl/nird_encode.sv
hdl/riu2_map.sv
hdl/nird_top.sv
sim/tb_nird.sv
